// File: rtl/csr_pkg.sv
/* csr package
   address map, op codes, register layouts and structs shared by the csr block */
package csr_pkg;

  ///////////////////////////////
  // address map
  ///////////////////////////////
  typedef enum logic [11:0] {
    CSR_MSTATUS        = 12'h300,
    CSR_MISA           = 12'h301,
    CSR_MIE            = 12'h304,
    CSR_MTVEC          = 12'h305,
    CSR_MCOUNTINHIBIT  = 12'h320,
    CSR_MHPMEVENT3     = 12'h323,  // event range start
    CSR_MHPMEVENT31    = 12'h33F,
    CSR_MSCRATCH       = 12'h340,
    CSR_MEPC           = 12'h341,
    CSR_MCAUSE         = 12'h342,
    CSR_MTVAL          = 12'h343,
    CSR_MIP            = 12'h344,
    CSR_MCYCLE         = 12'hB00,  // low counter range
    CSR_MINSTRET       = 12'hB02,
    CSR_MHPMCOUNTER3   = 12'hB03,
    CSR_MHPMCOUNTER31  = 12'hB1F,
    CSR_MCYCLEH        = 12'hB80,  // high counter range
    CSR_MINSTRETH      = 12'hB82,
    CSR_MHPMCOUNTER3H  = 12'hB83,
    CSR_MHPMCOUNTER31H = 12'hB9F,
    CSR_MVENDORID      = 12'hF11,
    CSR_MARCHID        = 12'hF12,
    CSR_MIMPID         = 12'hF13,
    CSR_MHARTID        = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ///////////////////////////////
  // register layouts
  ///////////////////////////////
  typedef struct packed {
    logic [18:0] zero_hi;
    logic [1:0]  mpp;
    logic [2:0]  zero_mid;
    logic        mpie;
    logic [2:0]  zero_lo;
    logic        mie;
    logic [2:0]  zero_b;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] addr;
    logic [5:0]  zero;
    logic [1:0]  mode;  // 01 = vectored
  } mtvec_t;

  typedef struct packed {
    logic        irq;
    logic [25:0] zero;
    logic [4:0]  code;
  } mcause_t;

  // write word, seen raw or through the trap register fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic        irq;      // mcause irq, also top bit of mtvec base
      logic [22:0] base_lo;  // rest of mtvec base
      logic        mpie;
      logic [2:0]  rsvd_hi;
      logic        mie;
      logic [1:0]  rsvd_lo;
      logic        mode;
    } fields;
  } csr_word_u;

  typedef struct packed {
    csr_addr_e   addr;
    csr_op_e     op;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    csr_addr_e addr;
    logic      we;
    csr_word_u wdata;  // already resolved
  } csr_wr_t;

  typedef struct packed {
    logic        save_cause;
    logic [5:0]  cause;  // [5] irq flag
    logic [31:0] trap_pc;
    logic        mret;
  } trap_ctrl_t;

  typedef struct packed {
    logic retire;
    logic ld_stall;
    logic jr_stall;
    logic imiss;
    logic load;
    logic store;
    logic jump;
    logic branch;
    logic branch_taken;
    logic compressed;
  } hpm_events_t;

  localparam logic [1:0]  PRIV_LVL_M        = 2'b11;
  localparam logic [31:0] MSTATUS_RESET_VAL = 32'h0000_1800;
  localparam logic [31:0] MTVEC_RESET_VAL   = 32'h0000_0001;
  localparam logic [31:0] IRQ_MASK          = 32'hFFFF_0888;  // msi, mti, mei, platform
  localparam logic [31:0] MISA_VALUE        = 32'h4000_1104;  // rv32imc
  localparam logic [31:0] MVENDORID_VALUE   = 32'h0000_0000;
  localparam logic [31:0] MARCHID_VALUE     = 32'h0000_0004;
  localparam int          NUM_HPM_EVENTS    = 11;  // cycle plus ten pulses

endpackage

// File: rtl/csr_access_unit.sv
/* csr access unit
   resolves read/write/set/clear into one write word and merges read data */
`timescale 1ns/1ps

module csr_access_unit #(
  parameter int NUM_MHPMCOUNTERS = 1
) (
  input  logic              csr_valid_i,
  input  csr_pkg::csr_req_t csr_req_i,
  input  logic [31:0]       trap_rdata_i,
  input  logic [31:0]       hpm_rdata_i,
  input  logic [31:0]       hart_id_i,
  input  logic [31:0]       mip_i,
  output csr_pkg::csr_wr_t  wr_o,
  output logic [31:0]       csr_rdata_o
);
  import csr_pkg::*;

  logic [31:0] const_rdata;
  logic [31:0] wword;
  logic [4:0]  idx;
  logic        hpm_range;
  logic        addr_ok;  // false for unimplemented counter slots

  // constant and read-only view
  always_comb begin
    case (csr_req_i.addr)
      CSR_MISA:      const_rdata = MISA_VALUE;
      CSR_MVENDORID: const_rdata = MVENDORID_VALUE;
      CSR_MARCHID:   const_rdata = MARCHID_VALUE;
      CSR_MHARTID:   const_rdata = hart_id_i;
      CSR_MIP:       const_rdata = mip_i;
      CSR_MIMPID,
      CSR_MTVAL:     const_rdata = '0;  // read zero
      default:       const_rdata = '0;
    endcase
  end

  // banks drive zero outside their own addresses
  assign csr_rdata_o = trap_rdata_i | hpm_rdata_i | const_rdata;

  ///////////////////////////////
  // write word
  ///////////////////////////////
  always_comb begin
    case (csr_req_i.op)
      CSR_OP_SET:   wword = csr_req_i.wdata | csr_rdata_o;
      CSR_OP_CLEAR: wword = ~csr_req_i.wdata & csr_rdata_o;
      default:      wword = csr_req_i.wdata;  // write, read never lands
    endcase
  end

  assign idx       = csr_req_i.addr[4:0];
  assign hpm_range = (csr_req_i.addr[11:5] == CSR_MCYCLE[11:5]) ||
                     (csr_req_i.addr[11:5] == CSR_MCYCLEH[11:5]);
  assign addr_ok   = !hpm_range || (idx == 5'd0) || (idx == 5'd2) ||
                     ((idx >= 5'd3) && (32'(idx) < NUM_MHPMCOUNTERS + 3));

  assign wr_o.addr      = csr_req_i.addr;
  assign wr_o.we        = csr_valid_i && (csr_req_i.op != CSR_OP_READ) && addr_ok;
  assign wr_o.wdata.raw = wword;

  // op must be known whenever a request is live
  always_comb begin
    if (csr_valid_i) begin
      a_op_known : assert #0 (!$isunknown(csr_req_i.op));
    end
  end

endmodule

// File: rtl/csr_trap_regs.sv
/* machine trap registers
   mstatus, mie, mtvec, mscratch, mepc, mcause with trap entry and mret updates */
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_wr_t    wr_i,
  input  csr_pkg::trap_ctrl_t trap_i,
  output logic [31:0]         rdata_o,
  output logic [31:0]         mie_bypass_o,
  output logic                m_irq_enable_o,
  output logic [31:0]         mepc_o,
  output logic [23:0]         mtvec_addr_o,
  output logic [1:0]          mtvec_mode_o
);
  import csr_pkg::*;

  mstatus_t    mstatus_q, mstatus_n;
  mtvec_t      mtvec_q, mtvec_n;
  mcause_t     mcause_q, mcause_n;
  logic [31:0] mie_q, mscratch_q, mepc_q, mepc_n;
  logic        mstatus_we, mie_we, mtvec_we, mscratch_we, mepc_we, mcause_we;
  csr_word_u   w;

  assign w = wr_i.wdata;

  // software write decode
  assign mstatus_we  = wr_i.we && (wr_i.addr == CSR_MSTATUS);
  assign mie_we      = wr_i.we && (wr_i.addr == CSR_MIE);
  assign mtvec_we    = wr_i.we && (wr_i.addr == CSR_MTVEC);
  assign mscratch_we = wr_i.we && (wr_i.addr == CSR_MSCRATCH);
  assign mepc_we     = wr_i.we && (wr_i.addr == CSR_MEPC);
  assign mcause_we   = wr_i.we && (wr_i.addr == CSR_MCAUSE);

  ///////////////////////////////
  // next state, trap wins
  ///////////////////////////////
  always_comb begin
    mstatus_n = mstatus_q;
    mepc_n    = mepc_q;
    mcause_n  = mcause_q;
    if (mstatus_we) begin
      mstatus_n      = '0;
      mstatus_n.mie  = w.fields.mie;
      mstatus_n.mpie = w.fields.mpie;
    end
    if (mepc_we) mepc_n = w.raw & ~32'd1;  // halfword aligned
    if (mcause_we) begin
      mcause_n      = '0;
      mcause_n.irq  = w.fields.irq;
      mcause_n.code = w.raw[4:0];
    end
    if (trap_i.save_cause) begin
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;
      mepc_n         = trap_i.trap_pc;
      mcause_n       = '0;
      mcause_n.irq   = trap_i.cause[5];
      mcause_n.code  = trap_i.cause[4:0];
    end else if (trap_i.mret) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end
    mstatus_n.mpp = PRIV_LVL_M;  // m-mode only
  end

  always_comb begin
    mtvec_n      = '0;
    mtvec_n.addr = {w.fields.irq, w.fields.base_lo};
    mtvec_n.mode = {1'b0, w.fields.mode};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= MSTATUS_RESET_VAL;
      mtvec_q    <= MTVEC_RESET_VAL;
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q <= mstatus_n;
      mepc_q    <= mepc_n;
      mcause_q  <= mcause_n;
      if (mtvec_we) mtvec_q <= mtvec_n;
      if (mie_we) mie_q <= w.raw & IRQ_MASK;
      if (mscratch_we) mscratch_q <= w.raw;
    end
  end

  always_comb begin
    case (wr_i.addr)
      CSR_MSTATUS:  rdata_o = mstatus_q;
      CSR_MIE:      rdata_o = mie_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = mcause_q;
      default:      rdata_o = '0;  // not ours
    endcase
  end

  assign mie_bypass_o   = mie_we ? (w.raw & IRQ_MASK) : mie_q;  // same-cycle view
  assign m_irq_enable_o = mstatus_q.mie;
  assign mepc_o         = mepc_q;
  assign mtvec_addr_o   = mtvec_q.addr;
  assign mtvec_mode_o   = mtvec_q.mode;

  // controller never saves and returns at once
  a_trap_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_i.save_cause && trap_i.mret));

endmodule

// File: rtl/csr_hpm_counters.sv
/* performance counters
   mcycle, minstret and programmable mhpmcounters with event select and inhibit */
`timescale 1ns/1ps

module csr_hpm_counters #(
  parameter int NUM_MHPMCOUNTERS  = 1,
  parameter int MHPMCOUNTER_WIDTH = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_wr_t     wr_i,
  input  csr_pkg::hpm_events_t hpm_events_i,
  output logic [31:0]          rdata_o
);
  import csr_pkg::*;

  logic [31:0][MHPMCOUNTER_WIDTH-1:0] cnt_q;
  logic [31:0][NUM_HPM_EVENTS-1:0]    evt_q;
  logic [31:0]                        inhibit_q;
  logic [31:0]                        wr_lo, wr_hi;
  logic [NUM_HPM_EVENTS-1:0]          events;
  logic [4:0]                         idx;
  logic                               lo_range, hi_range, evt_range;

  // bit 0 is the always-on cycle event
  assign events = {hpm_events_i.compressed, hpm_events_i.branch_taken,
                   hpm_events_i.branch, hpm_events_i.jump, hpm_events_i.store,
                   hpm_events_i.load, hpm_events_i.imiss, hpm_events_i.jr_stall,
                   hpm_events_i.ld_stall, hpm_events_i.retire, 1'b1};

  assign idx       = wr_i.addr[4:0];
  assign lo_range  = (wr_i.addr[11:5] == CSR_MCYCLE[11:5]);
  assign hi_range  = (wr_i.addr[11:5] == CSR_MCYCLEH[11:5]);
  assign evt_range = (wr_i.addr[11:5] == CSR_MHPMEVENT3[11:5]);

  ///////////////////////////////
  // counter slots
  ///////////////////////////////
  for (genvar i = 0; i < 32; i++) begin : gen_slot
    assign wr_lo[i] = wr_i.we && lo_range && (idx == 5'(i));
    assign wr_hi[i] = wr_i.we && hi_range && (idx == 5'(i)) && (MHPMCOUNTER_WIDTH == 64);

    if ((i == 1) || (i >= NUM_MHPMCOUNTERS + 3)) begin : gen_none
      assign cnt_q[i]     = '0;
      assign evt_q[i]     = '0;
      assign inhibit_q[i] = 1'b0;
    end else begin : gen_cnt
      logic [63:0] cur;  // widened view
      logic        ev;

      assign cur = 64'(cnt_q[i]);
      if (i == 0) begin : gen_cycle
        assign ev       = events[0];
        assign evt_q[i] = '0;
      end else if (i == 2) begin : gen_instret
        assign ev       = events[1];
        assign evt_q[i] = '0;
      end else begin : gen_prog
        assign ev = |(events & evt_q[i]);  // any selected event
        always_ff @(posedge clk or negedge rst_n) begin
          if (!rst_n) evt_q[i] <= '0;
          else if (wr_i.we && evt_range && (idx == 5'(i)))
            evt_q[i] <= wr_i.wdata.raw[NUM_HPM_EVENTS-1:0];
        end
      end

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          cnt_q[i]     <= '0;
          inhibit_q[i] <= 1'b1;  // off out of reset
        end else begin
          if (wr_i.we && (wr_i.addr == CSR_MCOUNTINHIBIT)) inhibit_q[i] <= wr_i.wdata.raw[i];
          if (wr_lo[i])
            cnt_q[i] <= MHPMCOUNTER_WIDTH'({cur[63:32], wr_i.wdata.raw});
          else if (wr_hi[i])
            cnt_q[i] <= MHPMCOUNTER_WIDTH'({wr_i.wdata.raw, cur[31:0]});
          else if (!inhibit_q[i] && ev)
            cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // read decode, inhibit sits at event slot 0
  always_comb begin
    if (wr_i.addr == CSR_MCOUNTINHIBIT) rdata_o = inhibit_q;
    else if (lo_range) rdata_o = cnt_q[idx][31:0];
    else if (hi_range) rdata_o = 32'(64'(cnt_q[idx]) >> 32);  // 0 for 32-bit counters
    else if (evt_range) rdata_o = 32'(evt_q[idx]);
    else rdata_o = '0;
  end

  a_mcycle_step : assert property (@(posedge clk) disable iff (!rst_n)
    (!inhibit_q[0] && !wr_lo[0] && !wr_hi[0])
      |=> (cnt_q[0] == MHPMCOUNTER_WIDTH'($past(cnt_q[0]) + 1'b1)));

endmodule

// File: rtl/csr_regfile_top.sv
/* csr register file top
   access unit feeding the trap register and counter banks */
`timescale 1ns/1ps

module csr_regfile_top #(
  parameter int NUM_MHPMCOUNTERS  = 1,
  parameter int MHPMCOUNTER_WIDTH = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 csr_valid_i,
  input  csr_pkg::csr_req_t    csr_req_i,
  output logic [31:0]          csr_rdata_o,
  input  logic [31:0]          hart_id_i,
  input  logic [31:0]          mip_i,
  input  csr_pkg::trap_ctrl_t  trap_i,
  input  csr_pkg::hpm_events_t hpm_events_i,
  output logic [31:0]          mie_bypass_o,
  output logic                 m_irq_enable_o,
  output logic [31:0]          mepc_o,
  output logic [23:0]          mtvec_addr_o,
  output logic [1:0]           mtvec_mode_o
);
  import csr_pkg::*;

  csr_wr_t     wr;          // shared by both banks
  logic [31:0] trap_rdata;
  logic [31:0] hpm_rdata;

  csr_access_unit #(
    .NUM_MHPMCOUNTERS (NUM_MHPMCOUNTERS)
  ) u_access (
    .csr_valid_i  (csr_valid_i),
    .csr_req_i    (csr_req_i),
    .trap_rdata_i (trap_rdata),
    .hpm_rdata_i  (hpm_rdata),
    .hart_id_i    (hart_id_i),
    .mip_i        (mip_i),
    .wr_o         (wr),
    .csr_rdata_o  (csr_rdata_o)
  );

  csr_trap_regs u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_i           (wr),
    .trap_i         (trap_i),
    .rdata_o        (trap_rdata),
    .mie_bypass_o   (mie_bypass_o),
    .m_irq_enable_o (m_irq_enable_o),
    .mepc_o         (mepc_o),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o)
  );

  csr_hpm_counters #(
    .NUM_MHPMCOUNTERS  (NUM_MHPMCOUNTERS),
    .MHPMCOUNTER_WIDTH (MHPMCOUNTER_WIDTH)
  ) u_hpm (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr),
    .hpm_events_i (hpm_events_i),
    .rdata_o      (hpm_rdata)
  );

endmodule

// File: include/csr_ref_model.svh
/* csr reference model
   shadow copy of the kept csrs, stepped once per rising clk */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

logic [31:0] m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause;
logic [31:0] m_inhibit;      // implemented bits only
logic [63:0] m_cnt [32];     // index = low address offset
logic [10:0] m_evt [32];

// counter slot exists: mcycle, minstret, mhpmcounter3 and up
function automatic bit cnt_impl(int i);
  return (i == 0) || (i == 2) || ((i >= 3) && (i < NUM_CNT + 3));
endfunction

function automatic logic [31:0] impl_mask();
  logic [31:0] m;
  m = '0;
  for (int i = 0; i < 32; i++) begin
    m[i] = cnt_impl(i);
  end
  return m;
endfunction

task automatic model_reset();
  m_mstatus  = 32'h0000_1800;  // mpp = M
  m_mtvec    = 32'h0000_0001;  // vectored, base 0
  m_mie      = '0;
  m_mscratch = '0;
  m_mepc     = '0;
  m_mcause   = '0;
  m_inhibit  = impl_mask();
  for (int i = 0; i < 32; i++) begin
    m_cnt[i] = '0;
    m_evt[i] = '0;
  end
endtask

function automatic logic [31:0] model_read(logic [11:0] a);
  logic [4:0] k;
  k = a[4:0];
  case (a)
    12'h300: return m_mstatus;
    12'h301: return 32'h4000_1104;  // mxl=1, I, M, C
    12'h304: return m_mie;
    12'h305: return m_mtvec;
    12'h320: return m_inhibit;
    12'h340: return m_mscratch;
    12'h341: return m_mepc;
    12'h342: return m_mcause;
    12'h344: return mip;
    12'hF11: return MVENDORID_VALUE;
    12'hF12: return MARCHID_VALUE;
    12'hF14: return hart_id;
    default: ;
  endcase
  if (a[11:5] == 7'h58) return m_cnt[k][31:0];           // 0xB00 block
  if (a[11:5] == 7'h5C) return (CNT_W == 64) ? m_cnt[k][63:32] : 32'h0;
  if (a[11:5] == 7'h19) return {21'b0, m_evt[k]};        // mhpmevent block
  return 32'h0;  // mimpid, mtval and holes
endfunction

// event seen by slot i this cycle
function automatic bit cnt_event(int i, logic [10:0] ev);
  if (i == 0) return 1'b1;
  if (i == 2) return ev[1];
  return |(ev & m_evt[i]);
endfunction

task automatic model_step();
  logic [11:0] a;
  logic [31:0] cur, w, st_old, inh_old;
  logic        we;
  logic [10:0] ev;
  a   = req.addr;
  cur = model_read(a);
  we  = csr_valid && (req.op != CSR_OP_READ);
  case (req.op)
    CSR_OP_SET:   w = cur | req.wdata;
    CSR_OP_CLEAR: w = cur & ~req.wdata;
    default:      w = req.wdata;
  endcase
  ev[0]  = 1'b1;                 // cycle
  ev[1]  = events.retire;
  ev[2]  = events.ld_stall;
  ev[3]  = events.jr_stall;
  ev[4]  = events.imiss;
  ev[5]  = events.load;
  ev[6]  = events.store;
  ev[7]  = events.jump;
  ev[8]  = events.branch;
  ev[9]  = events.branch_taken;
  ev[10] = events.compressed;
  inh_old = m_inhibit;
  st_old  = m_mstatus;

  ////////////////////////////// counters
  for (int i = 0; i < 32; i++) begin
    if (cnt_impl(i)) begin
      if (we && (a == 12'hB00 + 12'(i))) m_cnt[i][31:0] = w;
      else if (we && (a == 12'hB80 + 12'(i)) && (CNT_W == 64)) m_cnt[i][63:32] = w;
      else if (!inh_old[i] && cnt_event(i, ev)) m_cnt[i] = m_cnt[i] + 64'd1;
      if (CNT_W == 32) m_cnt[i][63:32] = '0;
    end
  end
  if (we && (a == 12'h320)) m_inhibit = w & impl_mask();
  if (we && (a[11:5] == 7'h19) && (a[4:0] >= 5'd3) && cnt_impl(int'(a[4:0])))
    m_evt[a[4:0]] = w[10:0];

  ////////////////////////////// trap registers
  if (we) begin
    case (a)
      12'h300: m_mstatus  = 32'h0000_1800 | (w & 32'h0000_0088);
      12'h304: m_mie      = w & 32'hFFFF_0888;
      12'h305: m_mtvec    = (w & 32'hFFFF_FF00) | (w & 32'h1);
      12'h340: m_mscratch = w;
      12'h341: m_mepc     = w & ~32'h1;
      12'h342: m_mcause   = w & 32'h8000_001F;
      default: ;
    endcase
  end
  if (trap.save_cause) begin     // trap beats software
    m_mstatus = 32'h0000_1800 | {24'b0, st_old[3], 7'b0};
    m_mepc    = trap.trap_pc;
    m_mcause  = {trap.cause[5], 26'b0, trap.cause[4:0]};
  end else if (trap.mret) begin
    m_mstatus = 32'h0000_1880 | {28'b0, st_old[7], 3'b0};
  end
endtask

`endif

// File: tests/tb_csr_regfile.sv
/* csr register file testbench
   random csr traffic, traps and counters checked against a shadow model */
`timescale 1ns/1ps

module tb_csr_regfile;
  import csr_pkg::*;

  localparam int NUM_CNT    = 1;
  localparam int CNT_W      = 64;
  localparam int CLK_PERIOD = 40;

  logic        clk;
  logic        rst_n;
  logic        csr_valid;
  csr_req_t    req;
  logic [31:0] rdata;
  logic [31:0] hart_id;
  logic [31:0] mip;
  trap_ctrl_t  trap;
  hpm_events_t events;
  logic [31:0] mie_bypass;
  logic        irq_en;
  logic [31:0] mepc;
  logic [23:0] mtvec_addr;
  logic [1:0]  mtvec_mode;

  logic [31:0] rng_state;
  logic [31:0] last_rdata;  // value sampled by the latest access
  int          checks, errors, tests;
  int          test_checks, test_errors;
  string       test_name;

  csr_addr_e trap_addrs [6] = '{CSR_MSCRATCH, CSR_MIE, CSR_MTVEC,
                                CSR_MEPC, CSR_MCAUSE, CSR_MSTATUS};
  csr_addr_e cnt_addrs  [6] = '{CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET,
                                CSR_MINSTRETH, CSR_MHPMCOUNTER3, CSR_MHPMCOUNTER3H};

  `include "csr_ref_model.svh"

  csr_regfile_top #(
    .NUM_MHPMCOUNTERS  (NUM_CNT),
    .MHPMCOUNTER_WIDTH (CNT_W)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_valid_i    (csr_valid),
    .csr_req_i      (req),
    .csr_rdata_o    (rdata),
    .hart_id_i      (hart_id),
    .mip_i          (mip),
    .trap_i         (trap),
    .hpm_events_i   (events),
    .mie_bypass_o   (mie_bypass),
    .m_irq_enable_o (irq_en),
    .mepc_o         (mepc),
    .mtvec_addr_o   (mtvec_addr),
    .mtvec_mode_o   (mtvec_mode)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  ////////////////////////////// compare tasks
  task automatic check_rdata(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s %s: expected 0x%08h actual 0x%08h", test_name, name, exp, act);
    end
  endtask

  task automatic check_status(string name, mstatus_t exp, mstatus_t act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s %s: expected 0x%08h actual 0x%08h (mie %b/%b mpie %b/%b)",
               test_name, name, exp, act, exp.mie, act.mie, exp.mpie, act.mpie);
    end
  endtask

  // mepc, global irq enable and mie bypass outputs
  task automatic check_trap_out(string name, logic [31:0] exp_mepc, logic exp_en,
                                logic [31:0] exp_bypass);
    checks++;
    test_checks++;
    if ((mepc !== exp_mepc) || (irq_en !== exp_en) || (mie_bypass !== exp_bypass)) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s %s: expected 0x%08h %b 0x%08h actual 0x%08h %b 0x%08h",
               test_name, name, exp_mepc, exp_en, exp_bypass, mepc, irq_en, mie_bypass);
    end
  endtask

  // mtvec base and mode outputs
  task automatic check_mtvec_out(string name, mtvec_t exp);
    checks++;
    test_checks++;
    if ((mtvec_addr !== exp.addr) || (mtvec_mode !== exp.mode)) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s %s: expected 0x%06h/%b actual 0x%06h/%b",
               test_name, name, exp.addr, exp.mode, mtvec_addr, mtvec_mode);
    end
  endtask

  ////////////////////////////// stimulus helpers
  task automatic cycle();
    @(posedge clk);
    model_step();
    @(negedge clk);
  endtask

  task automatic drive_idle();
    csr_valid = 1'b0;
    req.op    = CSR_OP_READ;
    req.wdata = '0;
    trap      = '0;
  endtask

  // one access from negedge to negedge, pre-edge read checked
  task automatic access(csr_addr_e addr, csr_op_e op, logic [31:0] wdata);
    csr_valid = 1'b1;
    req.addr  = addr;
    req.op    = op;
    req.wdata = wdata;
    #(CLK_PERIOD / 4);
    last_rdata = rdata;
    check_rdata($sformatf("read 0x%03h", addr), model_read(addr), rdata);
    cycle();
    drive_idle();
  endtask

  task automatic read_expect(string name, csr_addr_e addr, logic [31:0] exp);
    csr_valid = 1'b1;
    req.addr  = addr;
    req.op    = CSR_OP_READ;
    #(CLK_PERIOD / 4);
    check_rdata(name, exp, rdata);
    cycle();
    drive_idle();
  endtask

  task automatic read_status(string name);
    csr_valid = 1'b1;
    req.addr  = CSR_MSTATUS;
    req.op    = CSR_OP_READ;
    #(CLK_PERIOD / 4);
    check_status(name, mstatus_t'(m_mstatus), mstatus_t'(rdata));
    cycle();
    drive_idle();
  endtask

  // trap or mret, optionally racing a software mstatus write
  task automatic trap_event(logic save, logic ret, logic [5:0] cause, logic [31:0] pc,
                            logic sw_write, logic [31:0] sw_data);
    trap.save_cause = save;
    trap.mret       = ret;
    trap.cause      = cause;
    trap.trap_pc    = pc;
    if (sw_write) begin
      csr_valid = 1'b1;
      req.addr  = CSR_MSTATUS;
      req.op    = CSR_OP_WRITE;
      req.wdata = sw_data;
    end
    cycle();
    drive_idle();
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  ////////////////////////////// test sequence
  initial begin
    logic [31:0] r, w, first;
    int          n;
    bit          reached;
    rng_state = 32'd25;
    checks    = 0;
    errors    = 0;
    tests     = 0;
    rst_n     = 1'b0;
    csr_valid = 1'b0;
    req       = '{addr: CSR_MSTATUS, op: CSR_OP_READ, wdata: 32'h0};
    trap      = '0;
    events    = '0;
    hart_id   = 32'h0000_0003;
    mip       = '0;
    model_reset();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset");
    read_expect("mstatus", CSR_MSTATUS, 32'h0000_1800);
    read_expect("mtvec", CSR_MTVEC, 32'h0000_0001);
    read_expect("mcountinhibit", CSR_MCOUNTINHIBIT, impl_mask());
    for (int i = 0; i < 6; i++) begin
      read_expect("counter", cnt_addrs[i], 32'h0);
    end
    check_trap_out("outputs", 32'h0, 1'b0, 32'h0);
    check_mtvec_out("mtvec outputs", mtvec_t'(32'h0000_0001));
    end_test();

    begin_test("sw_access");
    for (int i = 0; i < 6; i++) begin
      access(trap_addrs[i], CSR_OP_WRITE, next_rand());  // seed each register
    end
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      access(trap_addrs[r % 6], csr_op_e'(r[5:4]), next_rand());
      access(trap_addrs[r % 6], CSR_OP_READ, '0);
      check_mtvec_out("mtvec outputs", mtvec_t'(m_mtvec));
    end
    end_test();

    begin_test("mie_bypass");
    for (int i = 0; i < 10; i++) begin
      w         = next_rand();
      csr_valid = 1'b1;
      req.addr  = CSR_MIE;
      req.op    = CSR_OP_WRITE;
      req.wdata = w;
      #(CLK_PERIOD / 4);
      check_trap_out("same cycle", m_mepc, m_mstatus[3], w & 32'hFFFF_0888);
      cycle();
      drive_idle();
      check_trap_out("after write", m_mepc, m_mstatus[3], w & 32'hFFFF_0888);
    end
    end_test();

    begin_test("trap_mret");
    for (int i = 0; i < 20; i++) begin
      access(CSR_MSTATUS, CSR_OP_WRITE, next_rand());
      r = next_rand();
      trap_event(1'b1, 1'b0, r[5:0], next_rand(), i[0], next_rand());
      check_trap_out("trap entry", m_mepc, m_mstatus[3], m_mie);
      access(CSR_MCAUSE, CSR_OP_READ, '0);
      read_status("after trap");
      trap_event(1'b0, 1'b1, '0, '0, i[1], next_rand());
      check_trap_out("mret", m_mepc, m_mstatus[3], m_mie);
      read_status("after mret");
    end
    end_test();

    begin_test("counters");
    r = next_rand();
    access(CSR_MHPMEVENT3, CSR_OP_WRITE, {21'b0, r[10:1], 1'b0});  // pulses only
    access(CSR_MHPMEVENT3, CSR_OP_READ, '0);
    access(CSR_MCOUNTINHIBIT, CSR_OP_CLEAR, 32'h0000_000D);
    // mcycle must climb once uninhibited
    n       = 0;
    reached = 1'b0;
    while (!reached && (n < 100)) begin
      r      = next_rand();
      events = hpm_events_t'(r[9:0]);
      access(CSR_MCYCLE, CSR_OP_READ, '0);
      reached = (last_rdata >= 32'd20);
      n++;
    end
    if (!reached) begin
      errors++;
      test_errors++;
      $display("timeout: mcycle did not reach 20 within 100 cycles");
    end
    for (int i = 0; i < 40; i++) begin
      r      = next_rand();
      events = hpm_events_t'(r[9:0]);
      access(cnt_addrs[r[31:16] % 6], CSR_OP_READ, '0);
    end
    access(CSR_MCYCLE, CSR_OP_WRITE, 32'hFFFF_FFF0);  // near carry into high half
    access(CSR_MINSTRETH, CSR_OP_WRITE, next_rand());
    access(CSR_MHPMCOUNTER3, CSR_OP_WRITE, next_rand());
    for (int i = 0; i < 30; i++) begin
      r      = next_rand();
      events = hpm_events_t'(r[9:0]);
      access(cnt_addrs[i % 6], CSR_OP_READ, '0);
    end
    access(CSR_MCOUNTINHIBIT, CSR_OP_SET, 32'h0000_000D);
    access(CSR_MINSTRET, CSR_OP_READ, '0);
    first = m_cnt[2][31:0];  // value held once inhibited
    for (int i = 0; i < 5; i++) begin
      r      = next_rand();
      events = hpm_events_t'(r[9:0] | 10'h200);  // retire held high
      cycle();
    end
    access(CSR_MINSTRET, CSR_OP_READ, '0);
    check_rdata("minstret frozen", first, last_rdata);
    events = '0;
    end_test();

    begin_test("constants");
    hart_id = next_rand();
    mip     = next_rand();
    read_expect("misa", CSR_MISA, 32'h4000_1104);
    read_expect("mvendorid", CSR_MVENDORID, MVENDORID_VALUE);
    read_expect("marchid", CSR_MARCHID, MARCHID_VALUE);
    read_expect("mhartid", CSR_MHARTID, hart_id);
    read_expect("mip", CSR_MIP, mip);
    read_expect("mimpid", CSR_MIMPID, 32'h0);
    read_expect("mtval", CSR_MTVAL, 32'h0);
    end_test();

    finish_run();
  end

endmodule

// File: flist.f
+incdir+include
rtl/csr_pkg.sv
rtl/csr_access_unit.sv
rtl/csr_trap_regs.sv
rtl/csr_hpm_counters.sv
rtl/csr_regfile_top.sv
tests/tb_csr_regfile.sv

// File: Bender.yml
package:
  name: csr_regfile

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_access_unit.sv
  - rtl/csr_trap_regs.sv
  - rtl/csr_hpm_counters.sv
  - rtl/csr_regfile_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_csr_regfile.sv
